/* gshare_pkg.sv */
package gshare_pkg;

    // Fetch and branch address width
    parameter int XLEN = 32;

    // Two-bit saturating direction counter
    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] ctr_t;

    // Strongest and weakest counter states
    parameter ctr_t CTR_MIN = 2'd0;
    parameter ctr_t CTR_MAX = 2'd3;

    // Counters leave reset weakly not taken
    parameter ctr_t CTR_INIT = 2'd1;

    // Next-PC sources, same encoding as the core's fetch mux
    typedef enum logic [1:0] {
        SEL_PLUS4      = 2'b00,
        SEL_RES_PLUS4  = 2'b01,
        SEL_BTB_TARGET = 2'b10,
        SEL_RES_TARGET = 2'b11
    } next_pc_sel_e;

    // Default target buffer index bits (64 entries)
    parameter int DEF_INDEX_WIDTH = 6;

    // Default global history length, also the counter table index width
    parameter int DEF_HISTORY_WIDTH = 4;

endpackage

/* pred_table.sv */
`timescale 1ns/1ps

module pred_table #(
    parameter int     INDEX_W   = 4,
    parameter type    entry_t   = logic [1:0],
    parameter entry_t RESET_VAL = '0
) (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Lookup port, answers in the same cycle
    input  logic [INDEX_W-1:0] rd_idx_i,
    output entry_t             rd_data_o,

    // Update port, visible to lookups from the next cycle on
    input  logic               wr_en_i,
    input  logic [INDEX_W-1:0] wr_idx_i,
    input  entry_t             wr_data_i
);

    localparam int DEPTH = 2 ** INDEX_W;

    entry_t mem_q [DEPTH];

    // Combinational read, no bypass from the write port
    assign rd_data_o = mem_q[rd_idx_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            // Whole table returns to its empty state
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_data_i;
        end
    end

    // An unknown write index would corrupt an arbitrary entry
    wr_idx_known_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wr_en_i |-> !$isunknown(wr_idx_i)
    ) else $error("pred_table: write index has unknown bits");

endmodule

/* branch_target_buffer.sv */
`timescale 1ns/1ps

module branch_target_buffer import gshare_pkg::*; #(
    parameter int INDEX_WIDTH = DEF_INDEX_WIDTH
) (
    input  logic            clk_i,
    input  logic            rst_ni,

    // Lookup with the current fetch address
    input  logic [XLEN-1:0] fetch_pc_i,
    output logic            hit_o,
    output logic [XLEN-1:0] target_o,
    output logic            is_jump_o,

    // Fill from a taken resolution
    input  logic            wr_en_i,
    input  logic [XLEN-1:0] wr_pc_i,
    input  logic [XLEN-1:0] wr_target_i,
    input  logic            wr_is_jump_i
);

    // Word aligned PCs, so bits 1:0 take no part in index or tag
    localparam int TAG_W = XLEN - INDEX_WIDTH - 2;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  target;
        logic             is_jump;
    } btb_entry_t;

    localparam btb_entry_t BTB_EMPTY = '0;

    logic [INDEX_WIDTH-1:0] rd_idx;
    logic [INDEX_WIDTH-1:0] wr_idx;
    logic [TAG_W-1:0]       rd_tag;
    btb_entry_t             rd_entry;
    btb_entry_t             wr_entry;

    // Fetch address split
    assign rd_idx = fetch_pc_i[INDEX_WIDTH+1:2];
    assign rd_tag = fetch_pc_i[XLEN-1:INDEX_WIDTH+2];

    // New entry from the resolved branch
    assign wr_idx           = wr_pc_i[INDEX_WIDTH+1:2];
    assign wr_entry.valid   = 1'b1;
    assign wr_entry.tag     = wr_pc_i[XLEN-1:INDEX_WIDTH+2];
    assign wr_entry.target  = wr_target_i;
    assign wr_entry.is_jump = wr_is_jump_i;

    pred_table #(
        .INDEX_W   (INDEX_WIDTH),
        .entry_t   (btb_entry_t),
        .RESET_VAL (BTB_EMPTY)
    ) btb_table_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (rd_idx),
        .rd_data_o (rd_entry),
        .wr_en_i   (wr_en_i),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_entry)
    );

    // Aliasing PCs share an index, the tag tells them apart
    assign hit_o     = rd_entry.valid && (rd_entry.tag == rd_tag);
    assign target_o  = rd_entry.target;
    assign is_jump_o = rd_entry.is_jump;

endmodule

/* gshare_direction.sv */
`timescale 1ns/1ps

module gshare_direction import gshare_pkg::*; #(
    parameter int HISTORY_WIDTH = DEF_HISTORY_WIDTH
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    // Fetch side lookup
    input  logic [XLEN-1:0]          fetch_pc_i,
    output logic                     pred_taken_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o,

    // Resolution of a conditional branch
    input  logic                     upd_en_i,
    input  logic [XLEN-1:0]          upd_pc_i,
    input  logic [HISTORY_WIDTH-1:0] upd_ghr_i,
    input  logic                     upd_taken_i
);

    logic [HISTORY_WIDTH-1:0] ghr_q;
    logic [HISTORY_WIDTH-1:0] rd_idx;
    logic [HISTORY_WIDTH-1:0] upd_idx;
    ctr_t                     fetch_ctr;
    ctr_t                     upd_ctr;
    ctr_t                     ctr_next;

    // Lookup uses the live history, update uses the history seen at fetch
    assign rd_idx  = fetch_pc_i[HISTORY_WIDTH+1:2] ^ ghr_q;
    assign upd_idx = upd_pc_i[HISTORY_WIDTH+1:2] ^ upd_ghr_i;

    // Two copies of the counters, written alike
    // One serves fetch, the other the read-modify-write of an update
    pred_table #(
        .INDEX_W   (HISTORY_WIDTH),
        .entry_t   (ctr_t),
        .RESET_VAL (CTR_INIT)
    ) pht_fetch_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (rd_idx),
        .rd_data_o (fetch_ctr),
        .wr_en_i   (upd_en_i),
        .wr_idx_i  (upd_idx),
        .wr_data_i (ctr_next)
    );

    pred_table #(
        .INDEX_W   (HISTORY_WIDTH),
        .entry_t   (ctr_t),
        .RESET_VAL (CTR_INIT)
    ) pht_upd_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (upd_idx),
        .rd_data_o (upd_ctr),
        .wr_en_i   (upd_en_i),
        .wr_idx_i  (upd_idx),
        .wr_data_i (ctr_next)
    );

    // Saturating step toward the resolved direction
    always_comb begin
        ctr_next = upd_ctr;
        if (upd_taken_i && (upd_ctr != CTR_MAX)) begin
            ctr_next = ctr_t'(upd_ctr + 2'd1);
        end else if (!upd_taken_i && (upd_ctr != CTR_MIN)) begin
            ctr_next = ctr_t'(upd_ctr - 2'd1);
        end
    end

    // History moves only on resolution, newest outcome in bit 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (upd_en_i) begin
            ghr_q <= (ghr_q << 1) | HISTORY_WIDTH'(upd_taken_i);
        end
    end

    assign pred_taken_o = fetch_ctr[1];
    assign ghr_o        = ghr_q;

    // Counter stored by the last write, read back at the same index
    ctr_no_wrap_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $past(upd_en_i) && (upd_idx == $past(upd_idx)) |->
            !(($past(upd_ctr) == CTR_MAX) && (upd_ctr == CTR_MIN)) &&
            !(($past(upd_ctr) == CTR_MIN) && (upd_ctr == CTR_MAX))
    ) else $error("gshare_direction: counter update wrapped");

endmodule

/* fetch_pc_gen.sv */
`timescale 1ns/1ps

module fetch_pc_gen import gshare_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            stall_i,

    // Prediction for the current fetch address
    input  logic            btb_hit_i,
    input  logic [XLEN-1:0] btb_target_i,
    input  logic            btb_is_jump_i,
    input  logic            dir_taken_i,

    // Resolved branch
    input  logic            res_valid_i,
    input  logic [XLEN-1:0] res_pc_i,
    input  logic [XLEN-1:0] res_target_i,
    input  logic            res_taken_i,
    input  logic            res_pred_taken_i,

    output logic [XLEN-1:0] pc_o,
    output logic            pred_taken_o,
    output logic            flush_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] res_plus4;
    logic [XLEN-1:0] next_pc;
    logic            pc_en;
    next_pc_sel_e    next_sel;

    assign pc_plus4  = pc_q + XLEN'(4);
    assign res_plus4 = res_pc_i + XLEN'(4);

    // Jumps in the buffer are always taken, branches follow the counter
    assign pred_taken_o = btb_hit_i && (btb_is_jump_i || dir_taken_i);

    // Misprediction when the actual direction differs from the fetch guess
    assign flush_o = res_valid_i && (res_taken_i != res_pred_taken_i);

    // Redirect wins over the prediction
    always_comb begin
        if (flush_o) begin
            next_sel = res_taken_i ? SEL_RES_TARGET : SEL_RES_PLUS4;
        end else if (pred_taken_o) begin
            next_sel = SEL_BTB_TARGET;
        end else begin
            next_sel = SEL_PLUS4;
        end
    end

    always_comb begin
        unique case (next_sel)
            SEL_PLUS4:      next_pc = pc_plus4;
            SEL_RES_PLUS4:  next_pc = res_plus4;
            SEL_BTB_TARGET: next_pc = btb_target_i;
            SEL_RES_TARGET: next_pc = res_target_i;
            default:        next_pc = pc_plus4;
        endcase
    end

    // A stall holds the PC, a redirect still goes through
    assign pc_en = flush_o || !stall_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else if (pc_en) begin
            pc_q <= next_pc;
        end
    end

    assign pc_o = pc_q;

    // Targets come from the buffer and the resolve port, both must stay aligned
    pc_aligned_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        pc_q[1:0] == 2'b00
    ) else $error("fetch_pc_gen: fetch address 0x%08h not word aligned", pc_q);

endmodule

/* gshare_fetch_top.sv */
`timescale 1ns/1ps

module gshare_fetch_top import gshare_pkg::*; #(
    parameter int INDEX_WIDTH   = DEF_INDEX_WIDTH,
    parameter int HISTORY_WIDTH = DEF_HISTORY_WIDTH
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     stall_i,

    // Fetch side
    output logic [XLEN-1:0]          pc_o,
    output logic                     pred_taken_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o,
    output logic                     flush_o,

    // Resolve side, one resolution per cycle at most
    input  logic                     res_valid_i,
    input  logic [XLEN-1:0]          res_pc_i,
    input  logic [XLEN-1:0]          res_target_i,
    input  logic                     res_taken_i,
    input  logic                     res_is_cond_i,
    input  logic                     res_pred_taken_i,
    input  logic [HISTORY_WIDTH-1:0] res_ghr_i
);

    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            btb_is_jump;
    logic            dir_taken;
    logic            btb_wr_en;
    logic            btb_wr_is_jump;
    logic            dir_upd_en;

    // Only taken branches get a buffer entry
    assign btb_wr_en      = res_valid_i && res_taken_i;
    assign btb_wr_is_jump = !res_is_cond_i;

    // Counters and history track conditional branches only
    assign dir_upd_en = res_valid_i && res_is_cond_i;

    fetch_pc_gen fetch_pc_gen_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .stall_i          (stall_i),
        .btb_hit_i        (btb_hit),
        .btb_target_i     (btb_target),
        .btb_is_jump_i    (btb_is_jump),
        .dir_taken_i      (dir_taken),
        .res_valid_i      (res_valid_i),
        .res_pc_i         (res_pc_i),
        .res_target_i     (res_target_i),
        .res_taken_i      (res_taken_i),
        .res_pred_taken_i (res_pred_taken_i),
        .pc_o             (pc_o),
        .pred_taken_o     (pred_taken_o),
        .flush_o          (flush_o)
    );

    branch_target_buffer #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) branch_target_buffer_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .fetch_pc_i   (pc_o),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .is_jump_o    (btb_is_jump),
        .wr_en_i      (btb_wr_en),
        .wr_pc_i      (res_pc_i),
        .wr_target_i  (res_target_i),
        .wr_is_jump_i (btb_wr_is_jump)
    );

    gshare_direction #(
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) gshare_direction_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .fetch_pc_i   (pc_o),
        .pred_taken_o (dir_taken),
        .ghr_o        (ghr_o),
        .upd_en_i     (dir_upd_en),
        .upd_pc_i     (res_pc_i),
        .upd_ghr_i    (res_ghr_i),
        .upd_taken_i  (res_taken_i)
    );

endmodule

/* tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int IDX_W     = DEF_INDEX_WIDTH;
localparam int HIST_W    = DEF_HISTORY_WIDTH;
localparam int BTB_DEPTH = 2 ** IDX_W;
localparam int PHT_DEPTH = 2 ** HIST_W;

// Mirror of the predictor state
logic              ref_valid  [BTB_DEPTH];
logic [XLEN-1:0]   ref_tag    [BTB_DEPTH];
logic [XLEN-1:0]   ref_target [BTB_DEPTH];
logic              ref_jump   [BTB_DEPTH];
logic [1:0]        ref_ctr    [PHT_DEPTH];
logic [HIST_W-1:0] ref_ghr;

logic [31:0] lfsr_state = 32'd96407;
int          check_count = 0;
int          mismatch_count = 0;

task automatic reset_model();
    for (int i = 0; i < BTB_DEPTH; i++) begin
        ref_valid[i]  = 1'b0;
        ref_tag[i]    = '0;
        ref_target[i] = '0;
        ref_jump[i]   = 1'b0;
    end
    for (int i = 0; i < PHT_DEPTH; i++) begin
        // Weakly not taken
        ref_ctr[i] = 2'd1;
    end
    ref_ghr = '0;
endtask

// Taken when the buffer hits and the entry is a jump or the counter is 2 or 3
function automatic logic predict_taken(input logic [XLEN-1:0] pc, input logic [HIST_W-1:0] ghr);
    logic [IDX_W-1:0]  bi;
    logic [HIST_W-1:0] ci;
    logic              hit;
    bi  = pc[IDX_W+1:2];
    ci  = pc[HIST_W+1:2] ^ ghr;
    hit = ref_valid[bi] && (ref_tag[bi] == (pc >> (IDX_W + 2)));
    return hit && (ref_jump[bi] || (ref_ctr[ci] >= 2'd2));
endfunction

function automatic logic expect_flush();
    return res_valid_i && (res_taken_i != res_pred_taken_i);
endfunction

// Next fetch address from the current one and the inputs of this cycle
function automatic logic [XLEN-1:0] expect_next_pc(input logic [XLEN-1:0] pc);
    logic [IDX_W-1:0] bi;
    bi = pc[IDX_W+1:2];
    if (expect_flush()) begin
        return res_taken_i ? res_target_i : res_pc_i + 32'd4;
    end
    if (stall_i) begin
        return pc;
    end
    if (predict_taken(pc, ref_ghr)) begin
        return ref_target[bi];
    end
    return pc + 32'd4;
endfunction

task automatic apply_resolution();
    logic [IDX_W-1:0]  bi;
    logic [HIST_W-1:0] ci;
    bi = res_pc_i[IDX_W+1:2];
    ci = res_pc_i[HIST_W+1:2] ^ res_ghr_i;
    if (res_valid_i && res_taken_i) begin
        ref_valid[bi]  = 1'b1;
        ref_tag[bi]    = res_pc_i >> (IDX_W + 2);
        ref_target[bi] = res_target_i;
        ref_jump[bi]   = !res_is_cond_i;
    end
    if (res_valid_i && res_is_cond_i) begin
        if (res_taken_i && (ref_ctr[ci] != 2'd3)) begin
            ref_ctr[ci] = ref_ctr[ci] + 2'd1;
        end else if (!res_taken_i && (ref_ctr[ci] != 2'd0)) begin
            ref_ctr[ci] = ref_ctr[ci] - 2'd1;
        end
        ref_ghr = {ref_ghr[HIST_W-2:0], res_taken_i};
    end
endtask

// Galois LFSR, one step per bit
function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], lfsr_bit()};
    end
    return value;
endfunction

task automatic check_value(input string test, input string name,
                           input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        mismatch_count++;
        $display("mismatch %s %s: expected 0x%08h actual 0x%08h at %0t",
                 test, name, expected, actual, $time);
    end
endtask

`endif

/* tb_gshare_fetch.sv */
`timescale 1ns/1ps

module tb_gshare_fetch import gshare_pkg::*; ();

    localparam int RESET_CYCLES    = 2;
    localparam int DIRECTED_CYCLES = 60;
    localparam int RANDOM_CYCLES   = 300;
    localparam int MAX_CYCLES      = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES);

    logic                         clk_i;
    logic                         rst_ni;
    logic                         stall_i;
    logic [XLEN-1:0]              pc_o;
    logic                         pred_taken_o;
    logic [DEF_HISTORY_WIDTH-1:0] ghr_o;
    logic                         flush_o;
    logic                         res_valid_i;
    logic [XLEN-1:0]              res_pc_i;
    logic [XLEN-1:0]              res_target_i;
    logic                         res_taken_i;
    logic                         res_is_cond_i;
    logic                         res_pred_taken_i;
    logic [DEF_HISTORY_WIDTH-1:0] res_ghr_i;

    `include "tb_ref_model.svh"

    logic [XLEN-1:0] exp_pc;
    string           test_name = "reset";
    int              cycle_count = 0;

    gshare_fetch_top gshare_fetch_top_inst (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .stall_i          (stall_i),
        .pc_o             (pc_o),
        .pred_taken_o     (pred_taken_o),
        .ghr_o            (ghr_o),
        .flush_o          (flush_o),
        .res_valid_i      (res_valid_i),
        .res_pc_i         (res_pc_i),
        .res_target_i     (res_target_i),
        .res_taken_i      (res_taken_i),
        .res_is_cond_i    (res_is_cond_i),
        .res_pred_taken_i (res_pred_taken_i),
        .res_ghr_i        (res_ghr_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic drive_idle(input int n, input logic stall);
        repeat (n) begin
            @(posedge clk_i);
            res_valid_i <= 1'b0;
            stall_i     <= stall;
        end
    endtask

    task automatic drive_resolve(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target,
                                 input logic taken, input logic is_cond, input logic pred,
                                 input logic [HIST_W-1:0] ghr, input logic stall);
        @(posedge clk_i);
        res_valid_i      <= 1'b1;
        res_pc_i         <= pc;
        res_target_i     <= target;
        res_taken_i      <= taken;
        res_is_cond_i    <= is_cond;
        res_pred_taken_i <= pred;
        res_ghr_i        <= ghr;
        stall_i          <= stall;
    endtask

    task automatic drive_random_cycle();
        logic            valid;
        logic            stall;
        logic            is_cond;
        logic            taken;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        valid   = lfsr_bit();
        stall   = lfsr_bit() & lfsr_bit();
        is_cond = lfsr_bit() | lfsr_bit();
        taken   = is_cond ? lfsr_bit() : 1'b1;
        // Two tag bits over three index bits, so PCs alias in the buffer
        pc      = (rand_bits(2) << 8) | (rand_bits(3) << 2);
        target  = rand_bits(10) << 2;
        if (valid) begin
            drive_resolve(pc, target, taken, is_cond, predict_taken(pc, ref_ghr), ref_ghr, stall);
        end else begin
            drive_idle(1, stall);
        end
    endtask

    task automatic report_counts();
        $display("summary: %0d checks, %0d mismatches", check_count, mismatch_count);
    endtask

    // Compare against the model mid-cycle, then advance the model
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            reset_model();
            exp_pc = '0;
        end else begin
            check_value(test_name, "pc_o", exp_pc, pc_o);
            check_value(test_name, "pred_taken_o", 32'(predict_taken(exp_pc, ref_ghr)),
                        32'(pred_taken_o));
            check_value(test_name, "ghr_o", 32'(ref_ghr), 32'(ghr_o));
            check_value(test_name, "flush_o", 32'(expect_flush()), 32'(flush_o));
            exp_pc = expect_next_pc(exp_pc);
            apply_resolution();
        end
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            report_counts();
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        rst_ni           = 1'b0;
        stall_i          = 1'b0;
        res_valid_i      = 1'b0;
        res_pc_i         = '0;
        res_target_i     = '0;
        res_taken_i      = 1'b0;
        res_is_cond_i    = 1'b0;
        res_pred_taken_i = 1'b0;
        res_ghr_i        = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;

        test_name = "sequential_fetch";
        drive_idle(16, 1'b0);

        // Hold, then a redirect while still stalled
        test_name = "stall";
        drive_idle(4, 1'b1);
        drive_resolve(32'h100, 32'h200, 1'b1, 1'b1, 1'b0, ref_ghr, 1'b1);
        @(negedge clk_i);
        check_value(test_name, "flush_o", 32'd1, 32'(flush_o));
        drive_idle(1, 1'b1);
        @(negedge clk_i);
        check_value(test_name, "pc_o", 32'h200, pc_o);
        drive_idle(3, 1'b0);

        // Fill a jump, then steer fetch onto it
        test_name = "jump_btb";
        drive_resolve(32'h300, 32'h400, 1'b1, 1'b0, 1'b0, ref_ghr, 1'b0);
        drive_resolve(32'h2FC, 32'h2F0, 1'b0, 1'b1, 1'b1, ref_ghr, 1'b0);
        drive_idle(1, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "pc_o", 32'h300, pc_o);
        check_value(test_name, "pred_taken_o", 32'd1, 32'(pred_taken_o));
        drive_idle(1, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "pc_o", 32'h400, pc_o);
        drive_idle(2, 1'b0);

        test_name = "mispredict";
        drive_resolve(32'h500, 32'h600, 1'b1, 1'b1, 1'b0, ref_ghr, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "flush_o", 32'd1, 32'(flush_o));
        drive_idle(1, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "pc_o", 32'h600, pc_o);
        drive_resolve(32'h500, 32'h600, 1'b0, 1'b1, 1'b1, ref_ghr, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "flush_o", 32'd1, 32'(flush_o));
        drive_idle(1, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "pc_o", 32'h504, pc_o);
        drive_idle(2, 1'b0);

        // History of all ones stays all ones after more taken outcomes
        test_name = "training";
        for (int i = 0; i < 4; i++) begin
            drive_resolve(32'h800 + 32'(4 * i), 32'h900, 1'b1, 1'b1, 1'b1, ref_ghr, 1'b0);
        end
        drive_resolve(32'h700, 32'hA00, 1'b1, 1'b1, 1'b0, 4'hF, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "ghr_o", 32'hF, 32'(ghr_o));
        drive_resolve(32'h700, 32'hA00, 1'b1, 1'b1, 1'b0, 4'hF, 1'b0);
        drive_resolve(32'h6FC, 32'h700, 1'b1, 1'b0, 1'b0, ref_ghr, 1'b0);
        drive_idle(1, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "pc_o", 32'h700, pc_o);
        check_value(test_name, "ghr_o", 32'hF, 32'(ghr_o));
        check_value(test_name, "pred_taken_o", 32'd1, 32'(pred_taken_o));
        drive_idle(1, 1'b0);
        @(negedge clk_i);
        check_value(test_name, "pc_o", 32'hA00, pc_o);
        drive_idle(2, 1'b0);

        test_name = "random_mix";
        repeat (RANDOM_CYCLES) drive_random_cycle();
        drive_idle(2, 1'b0);

        report_counts();
        if (mismatch_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
gshare_pkg.sv
pred_table.sv
branch_target_buffer.sv
gshare_direction.sv
fetch_pc_gen.sv
gshare_fetch_top.sv
tb_gshare_fetch.sv

/* Makefile */
SRCS = gshare_pkg.sv pred_table.sv branch_target_buffer.sv gshare_direction.sv \
       fetch_pc_gen.sv gshare_fetch_top.sv tb_gshare_fetch.sv tb_ref_model.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_gshare_fetch: project.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_gshare_fetch \
		-f project.f -o Vtb_gshare_fetch

sim.log: obj_dir/Vtb_gshare_fetch
	./obj_dir/Vtb_gshare_fetch > sim.log

run: sim.log
	@cat sim.log
	@grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
